//--- controlDecoder.sv
// Control word decoder
`timescale 1ns/10ps

module controlDecoder (
   seqIf.consumer             seq,
   input  logic               branchTaken,
   output logic               flagsWe,
   output ctrlPkg::aluFn_t    aluOp,
   output ctrlPkg::op1Sel_t   op1Sel,
   output ctrlPkg::op2Sel_t   op2Sel,
   output ctrlPkg::immSel_t   immSel,
   output ctrlPkg::wdSel_t    wdSel,
   output ctrlPkg::pcSel_t    pcSel,
   output ctrlPkg::lrSel_t    lrSel,
   output ctrlPkg::rs1Sel_t   rs1Sel,
   output logic               aluEn,
   output logic               aluWe,
   output logic               lrEn,
   output logic               lrWe,
   output logic               pcWe,
   output logic               pcEn,
   output logic               irWe,
   output logic               regWe,
   output logic               memEn,
   output logic               nWE,
   output logic               nOE,
   output logic               nME,
   output logic               enb,
   output logic               ale
);

   import isaPkg::*;
   import ctrlPkg::*;

   function automatic aluFn_t aluFnOf(opcode_t op);
      case (op)
         ADD, ADDI:            return FnADD;
         SUB, SUBI, CMP, CMPI: return FnSUB;
         AND:                  return FnAND;
         OR:                   return FnOR;
         XOR:                  return FnXOR;
         NOT:                  return FnNOT;
         NAND:                 return FnNAND;
         NOR:                  return FnNOR;
         NEG:                  return FnNEG;
         LSL:                  return FnLSL;
         LSR:                  return FnLSR;
         ASR:                  return FnASR;
         default:              return FnA;
      endcase
   endfunction

   always_comb begin
      aluOp   = FnA;
      op1Sel  = Op1Rd1;
      op2Sel  = Op2Imm;
      immSel  = ImmLong;
      wdSel   = WdAlu;
      pcSel   = Pc1;
      lrSel   = LrSys;
      rs1Sel  = Rs1Ra;
      aluEn   = 1'b0;
      aluWe   = 1'b0;
      lrEn    = 1'b0;
      lrWe    = 1'b0;
      pcWe    = 1'b0;
      pcEn    = 1'b0;
      irWe    = 1'b0;
      regWe   = 1'b0;
      memEn   = 1'b0;
      nWE     = 1'b0;
      nOE     = 1'b0;
      nME     = 1'b1;
      enb     = 1'b0;
      ale     = 1'b0;
      flagsWe = 1'b0;
      if (seq.phase == fetch) begin
         case (seq.step)
            cycle0: begin                     // PC out as address
               ale  = 1'b1;
               nWE  = 1'b1;
               nOE  = 1'b1;
               pcEn = 1'b1;
            end
            cycle1: begin
               nME   = 1'b0;
               nWE   = 1'b1;
               memEn = 1'b1;
            end
            cycle2: begin
               nME   = 1'b0;
               nWE   = 1'b1;
               memEn = 1'b1;
               enb   = 1'b1;
            end
            cycle3: begin
               nWE   = 1'b1;
               memEn = 1'b1;
               irWe  = 1'b1;                  // Instruction into IR
            end
            default: ;
         endcase
      end else begin
         case (seq.step)
            cycle0: begin
               case (seq.opcode)
                  LDW, STW: begin             // Address add first
                     aluEn  = 1'b1;
                     aluWe  = 1'b1;
                     immSel = ImmShort;
                     aluOp  = FnADD;
                  end
                  BRANCH: begin
                     pcWe = 1'b1;
                     if (seq.branchCode == RET) begin
                        lrEn  = 1'b1;
                        pcSel = PcSysbus;
                     end else begin
                        aluOp  = FnADD;
                        op1Sel = Op1Pc;
                        aluEn  = 1'b1;
                        if (branchTaken) begin
                           pcSel = PcAluOut;
                           if (seq.branchCode == BWL) begin
                              lrWe  = 1'b1;
                              lrSel = LrPc;
                           end
                        end
                     end
                  end
                  ADD, ADDI, SUB, SUBI, CMP, CMPI, AND, OR, XOR, NOT, NAND, NOR, NEG, LSL,
                  LSR, ASR: begin
                     pcEn    = 1'b1;
                     pcWe    = 1'b1;
                     flagsWe = 1'b1;
                     regWe   = !(seq.opcode inside {CMP, CMPI});  // Compare keeps Rd
                     aluOp   = aluFnOf(seq.opcode);
                     if (seq.opcode inside {ADDI, SUBI, CMPI, LSL, LSR, ASR})
                        immSel = ImmShort;
                     if (seq.opcode inside {ADD, SUB, CMP, AND, OR, XOR, NAND, NOR})
                        op2Sel = Op2Rd2;
                  end
                  default: begin              // Undefined opcode, skip
                     pcEn = 1'b1;
                     pcWe = 1'b1;
                  end
               endcase
            end
            cycle1: begin                     // Address latch
               ale    = 1'b1;
               nWE    = 1'b1;
               nOE    = 1'b1;
               immSel = ImmShort;
               aluOp  = FnADD;
               aluEn  = 1'b1;
            end
            cycle2: begin
               nME    = 1'b0;
               rs1Sel = Rs1Rd;                // Store data from Rd
               nWE    = 1'b1;
               aluWe  = 1'b1;
               aluEn  = 1'b1;
               if (seq.opcode == LDW)
                  memEn = 1'b1;
               else
                  nOE   = 1'b1;
            end
            cycle3: begin
               nME = 1'b0;
               if (seq.opcode == LDW) begin
                  memEn = 1'b1;
                  enb   = 1'b1;
                  nWE   = 1'b1;
               end else begin
                  aluEn = 1'b1;               // Hold data on sysbus
                  nOE   = 1'b1;
               end
            end
            cycle4: begin
               pcWe = 1'b1;
               if (seq.opcode == LDW) begin
                  nWE   = 1'b1;
                  memEn = 1'b1;
                  wdSel = WdSys;
                  regWe = 1'b1;
               end else begin
                  nOE   = 1'b1;
                  aluEn = 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

//--- controlUnit.sv
// Processor control unit
`timescale 1ns/10ps
`include "cpu_defines.svh"

module controlUnit (
   input  logic                 Clock,
   input  logic                 nReset,
   input  logic                 nWait,
   input  logic [`INSTR_W-1:0]  OpcodeCondIn,
   input  logic [`FLAGS_W-1:0]  Flags,
   output ctrlPkg::aluFn_t      AluOp,
   output ctrlPkg::op1Sel_t     Op1Sel,
   output ctrlPkg::op2Sel_t     Op2Sel,
   output logic                 AluEn,
   output logic                 LrEn,
   output logic                 LrWe,
   output ctrlPkg::lrSel_t      LrSel,
   output logic                 PcWe,
   output logic                 PcEn,
   output logic                 IrWe,
   output ctrlPkg::wdSel_t      WdSel,
   output ctrlPkg::immSel_t     ImmSel,
   output logic                 RegWe,
   output ctrlPkg::pcSel_t      PcSel,
   output logic                 MemEn,   // Pad control
   output logic                 nWE,     // Memory strobes
   output logic                 nOE,
   output logic                 nME,
   output logic                 ENB,
   output logic                 ALE,
   output ctrlPkg::rs1Sel_t     Rs1Sel,
   output logic                 AluWe
);

   import isaPkg::*;

   logic flagsWe;
   logic branchTaken;

   seqIf seqBus ();

   assign seqBus.opcode     = opcode_t'(OpcodeCondIn[`INSTR_W-1 -: `OPCODE_W]);
   assign seqBus.branchCode = branch_t'(OpcodeCondIn[`BRCODE_W-1:0]);

   sequencer seq0 (.Clock(Clock), .nReset(nReset), .nWait(nWait), .seq(seqBus.producer));

   statusFlags flags0 (
      .Clock(Clock), .nReset(nReset), .flags(Flags), .flagsWe(flagsWe),
      .branchCode(seqBus.branchCode), .branchTaken(branchTaken)
   );

   controlDecoder dec0 (
      .seq(seqBus.consumer), .branchTaken(branchTaken), .flagsWe(flagsWe),
      .aluOp(AluOp), .op1Sel(Op1Sel), .op2Sel(Op2Sel), .immSel(ImmSel),
      .wdSel(WdSel), .pcSel(PcSel), .lrSel(LrSel), .rs1Sel(Rs1Sel),
      .aluEn(AluEn), .aluWe(AluWe), .lrEn(LrEn), .lrWe(LrWe),
      .pcWe(PcWe), .pcEn(PcEn), .irWe(IrWe), .regWe(RegWe),
      .memEn(MemEn), .nWE(nWE), .nOE(nOE), .nME(nME),
      .enb(ENB), .ale(ALE)
   );

endmodule

//--- controlUnit_assertions.sv
// Control unit strobe assertions
`timescale 1ns/10ps

module controlUnit_assertions (
   input logic Clock,
   input logic nReset,
   input logic IrWe,
   input logic RegWe,
   input logic ALE,
   input logic nME
);

   irWeSingle: assert property (@(posedge Clock) disable iff (!nReset) IrWe |=> !IrWe)
      else $error("IrWe stayed high for two cycles");

   irRegExclusive: assert property (@(posedge Clock) disable iff (!nReset) !(IrWe && RegWe))
      else $error("IrWe and RegWe high together");

   // Address latch only while the memory is deselected
   aleIdle: assert property (@(posedge Clock) disable iff (!nReset) !(ALE && !nME))
      else $error("ALE high while nME low");

endmodule

bind controlUnit controlUnit_assertions assert0 (
   .Clock(Clock), .nReset(nReset), .IrWe(IrWe), .RegWe(RegWe), .ALE(ALE), .nME(nME)
);

//--- controlUnit_tb.sv
// Control unit testbench
`timescale 1ns/10ps
`include "cpu_defines.svh"

module controlUnit_tb;

   import isaPkg::*;
   import ctrlPkg::*;

   localparam int RECORDS = 29;
   localparam int FIELDS  = 7;        // Byte columns per data record

   logic                Clock;
   logic                nReset;
   logic                nWait;
   logic [`INSTR_W-1:0] OpcodeCondIn;
   logic [`FLAGS_W-1:0] Flags;
   aluFn_t              AluOp;
   op1Sel_t             Op1Sel;
   op2Sel_t             Op2Sel;
   logic                AluEn;
   logic                LrEn;
   logic                LrWe;
   lrSel_t              LrSel;
   logic                PcWe;
   logic                PcEn;
   logic                IrWe;
   wdSel_t              WdSel;
   immSel_t             ImmSel;
   logic                RegWe;
   pcSel_t              PcSel;
   logic                MemEn;
   logic                nWE;
   logic                nOE;
   logic                nME;
   logic                ENB;
   logic                ALE;
   rs1Sel_t             Rs1Sel;
   logic                AluWe;

   logic [7:0] testMem [0:RECORDS*FIELDS-1];
   int         cycleCount = 0;
   int         cycleLimit = 0;
   int         recIdx = 0;
   bit         endReported = 1'b0;

   controlUnit dut0 (.*);

   initial Clock = 1'b0;
   always #4 Clock = ~Clock;          // 8 ns period

   always @(posedge Clock) begin
      cycleCount = cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         endReported = 1'b1;
         $display("Timeout: the test records did not complete within %0d cycles", cycleLimit);
         $display("ERRORS FOUND");
         $fatal(1, "Cycle limit reached");
      end
   end

   task automatic reportMismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      endReported = 1'b1;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h (record %0d)", name, got, exp, recIdx);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s", name);
   endtask

   task automatic checkAluFn(input string name, input aluFn_t got, input aluFn_t exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkPcSel(input string name, input pcSel_t got, input pcSel_t exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkWdSel(input string name, input wdSel_t got, input wdSel_t exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkOp1Sel(input string name, input op1Sel_t got, input op1Sel_t exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkOp2Sel(input string name, input op2Sel_t got, input op2Sel_t exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkImmSel(input string name, input immSel_t got, input immSel_t exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkLrSel(input string name, input lrSel_t got, input lrSel_t exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkRs1Sel(input string name, input rs1Sel_t got, input rs1Sel_t exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp)
         reportMismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic checkCount(input string name, input int got, input int exp);
      if (got != exp)
         reportMismatch(name, got, exp);
   endtask

   task automatic nextCycle;
      @(posedge Clock);
      @(negedge Clock);
   endtask

   // Low inside the window [first, last)
   function automatic logic nWaitAt(input int idx, input int first, input int last);
      return !(idx >= first && idx < last);
   endfunction

   task automatic checkResetOutputs;
      checkBit("RegWe", RegWe, 1'b0);
      checkBit("PcWe", PcWe, 1'b0);
      checkBit("IrWe", IrWe, 1'b0);
      checkBit("MemEn", MemEn, 1'b0);
      checkBit("ENB", ENB, 1'b0);
      checkBit("AluWe", AluWe, 1'b0);
      checkBit("LrEn", LrEn, 1'b0);
      checkBit("LrWe", LrWe, 1'b0);
      checkBit("nME", nME, 1'b1);
      checkBit("ALE", ALE, 1'b1);
      checkBit("nWE", nWE, 1'b1);
      checkBit("nOE", nOE, 1'b1);
      checkBit("PcEn", PcEn, 1'b1);
   endtask

   // Starts at a falling edge in fetch cycle0, returns at the next one
   task automatic runRecord(input int r);
      int      base;
      int      fetchWaits;
      int      execWaits;
      int      idx;
      int      waitFrom;
      opcode_t op;
      branch_t code;
      logic    memOp;
      logic    aluInstr;
      pcSel_t  expPc;
      base       = r * FIELDS;
      recIdx     = r;
      op         = opcode_t'(testMem[base][`INSTR_W-1 -: `OPCODE_W]);
      code       = branch_t'(testMem[base][`BRCODE_W-1:0]);
      memOp      = (op == LDW) || (op == STW);
      aluInstr   = !memOp && (op != BRANCH);
      expPc      = pcSel_t'(testMem[base+5][1:0]);
      fetchWaits = int'(testMem[base+2]);
      execWaits  = int'(testMem[base+3]);
      OpcodeCondIn = testMem[base];
      Flags        = testMem[base+1][`FLAGS_W-1:0];

      idx      = 0;
      waitFrom = (fetchWaits > 0) ? int'($urandom % 3) : 2;
      while (!IrWe) begin
         nWait = nWaitAt(idx, waitFrom, 2 + fetchWaits);
         checkBit("nME", nME, !(idx >= 1 && idx <= 2 + fetchWaits));
         nextCycle();
         idx++;
      end
      nWait = 1'b1;
      checkCount("IrWe cycle", idx + 1, 4 + fetchWaits);
      nextCycle();

      // Execute cycle0
      checkAluFn("AluOp", AluOp, aluFn_t'(testMem[base+4][3:0]));
      checkPcSel("PcSel", PcSel, expPc);
      checkBit("RegWe", RegWe, testMem[base+6][0]);
      if (op == BRANCH) begin
         checkBit("LrWe", LrWe, code == BWL);
         checkBit("LrEn", LrEn, code == RET);
         if (expPc == PcAluOut) begin          // Target is PC plus offset
            checkOp1Sel("Op1Sel", Op1Sel, Op1Pc);
            checkImmSel("ImmSel", ImmSel, ImmLong);
            checkBit("AluEn", AluEn, 1'b1);
         end
         if (code == BWL)
            checkLrSel("LrSel", LrSel, LrPc);
      end
      if (aluInstr) begin
         checkRs1Sel("Rs1Sel", Rs1Sel, Rs1Ra);
         if (op inside {ADDI, SUBI, CMPI}) begin
            checkImmSel("ImmSel", ImmSel, ImmShort);
            checkOp2Sel("Op2Sel", Op2Sel, Op2Imm);
         end else if (op inside {ADD, SUB, CMP}) begin
            checkOp2Sel("Op2Sel", Op2Sel, Op2Rd2);
         end
      end
      idx      = 0;
      waitFrom = (execWaits > 0) ? 1 + int'($urandom % 3) : 3;
      while (!PcWe) begin
         nWait = nWaitAt(idx, waitFrom, 3 + execWaits);
         nextCycle();
         idx++;
      end
      nWait = 1'b1;
      checkCount("PcWe cycle", idx + 1, memOp ? 5 + execWaits : 1);
      if (memOp) begin
         checkBit("RegWe", RegWe, op == LDW);
         if (op == LDW)
            checkWdSel("WdSel", WdSel, WdSys);
         else
            checkWdSel("WdSel", WdSel, WdAlu);
      end
      nextCycle();
   endtask

   initial begin
      void'($urandom(32'hdd5b354e));
      nReset       = 1'b0;
      nWait        = 1'b1;
      OpcodeCondIn = '0;
      Flags        = '0;
      $readmemh("controlUnit_testdata.txt", testMem);
      cycleLimit = 20;
      for (int r = 0; r < RECORDS; r++)
         cycleLimit = cycleLimit + 2 * (9 + int'(testMem[r*FIELDS+2]) +
                                        int'(testMem[r*FIELDS+3]));
      repeat (5) @(negedge Clock);
      checkResetOutputs();
      nReset = 1'b1;
      for (int r = 0; r < RECORDS; r++)
         runRecord(r);
      endReported = 1'b1;
      $display("NO ERRORS");
      $finish;
   end

   // Run stopped by something other than the checks above
   final begin
      if (!endReported)
         $display("ERRORS FOUND");
   end

endmodule

//--- controlUnit_testdata.txt
// instr flags fetchWaits execWaits aluOp pcSel regWe   (hex, one record per line)
// flags bits: Z=0 N=1 V=2 C=3; instr = opcode<<3 | branch code
92 0 0 0 1 0 0
00 0 1 0 1 0 1
08 0 0 0 1 0 1
10 0 2 0 2 0 1
18 0 0 0 2 0 1
30 0 0 0 3 0 1
38 0 1 0 4 0 1
40 0 0 0 5 0 1
48 0 0 0 6 0 1
50 0 0 0 7 0 1
58 0 3 0 8 0 1
60 0 0 0 9 0 1
68 0 0 0 a 0 1
70 0 0 0 b 0 1
78 0 0 0 c 0 1
20 1 0 0 2 0 0
92 0 0 0 1 1 0
91 0 0 0 1 0 0
28 2 1 0 2 0 0
93 0 0 0 1 1 0
94 0 0 0 1 0 0
80 0 1 2 1 0 0
88 0 0 1 1 0 0
20 6 0 0 2 0 0
94 0 0 0 1 1 0
91 0 0 0 1 1 0
95 0 0 0 1 1 0
96 0 0 0 0 2 0
90 0 2 0 1 1 0

//--- cpu_defines.svh
// CPU field widths
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Instruction byte fields
`define INSTR_W   8
`define OPCODE_W  5
`define BRCODE_W  3

// ALU status flags
`define FLAGS_W   4

// Bit positions within the flag vector
`define FLAG_Z    0
`define FLAG_N    1
`define FLAG_V    2
`define FLAG_C    3

`endif

//--- ctrlPkg.sv
// Control word encodings
package ctrlPkg;

   typedef enum logic {
      fetch   = 1'b0,
      execute = 1'b1
   } phase_t;

   typedef enum logic [2:0] {
      cycle0 = 3'd0,
      cycle1 = 3'd1,
      cycle2 = 3'd2,
      cycle3 = 3'd3,
      cycle4 = 3'd4
   } step_t;

   typedef enum logic [3:0] {
      FnA    = 4'd0,     // Pass operand 1
      FnADD  = 4'd1,
      FnSUB  = 4'd2,
      FnAND  = 4'd3,
      FnOR   = 4'd4,
      FnXOR  = 4'd5,
      FnNOT  = 4'd6,
      FnNAND = 4'd7,
      FnNOR  = 4'd8,
      FnNEG  = 4'd9,
      FnLSL  = 4'd10,
      FnLSR  = 4'd11,
      FnASR  = 4'd12
   } aluFn_t;

   typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
   typedef enum logic {Op2Imm, Op2Rd2} op2Sel_t;
   typedef enum logic {ImmLong, ImmShort} immSel_t;
   typedef enum logic {WdAlu, WdSys} wdSel_t;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSel_t;
   typedef enum logic {LrSys, LrPc} lrSel_t;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1Sel_t;

endpackage

//--- isaPkg.sv
// Instruction set encodings
`include "cpu_defines.svh"

package isaPkg;

   typedef enum logic [`OPCODE_W-1:0] {
      ADD    = 'd0,
      ADDI   = 'd1,
      SUB    = 'd2,
      SUBI   = 'd3,
      CMP    = 'd4,
      CMPI   = 'd5,
      AND    = 'd6,
      OR     = 'd7,
      XOR    = 'd8,
      NOT    = 'd9,
      NAND   = 'd10,
      NOR    = 'd11,
      NEG    = 'd12,
      LSL    = 'd13,
      LSR    = 'd14,
      ASR    = 'd15,
      LDW    = 'd16,
      STW    = 'd17,
      BRANCH = 'd18     // Condition held in the low bits
   } opcode_t;

   typedef enum logic [`BRCODE_W-1:0] {
      BR  = 'd0,
      BNE = 'd1,
      BE  = 'd2,
      BLT = 'd3,
      BGE = 'd4,
      BWL = 'd5,        // Branch with link
      RET = 'd6
   } branch_t;

endpackage

//--- list.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
seqIf.sv
sequencer.sv
statusFlags.sv
controlDecoder.sv
controlUnit.sv
controlUnit_assertions.sv
controlUnit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module controlUnit_tb -o controlUnit_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/controlUnit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

//--- seqIf.sv
// Sequencer to decoder bus
`timescale 1ns/10ps

interface seqIf;

   import isaPkg::*;
   import ctrlPkg::*;

   phase_t  phase;
   step_t   step;
   opcode_t opcode;
   branch_t branchCode;

   modport producer (output phase, output step, input opcode);
   modport top (output opcode, output branchCode);
   modport consumer (input phase, input step, input opcode, input branchCode);

endinterface

//--- sequencer.sv
// Fetch and execute sequencer
`timescale 1ns/10ps

module sequencer (
   input  logic   Clock,
   input  logic   nReset,
   input  logic   nWait,
   seqIf.producer seq
);

   import isaPkg::*;
   import ctrlPkg::*;

   phase_t phaseNext;
   step_t  stepNext;

   always_comb begin
      phaseNext = seq.phase;
      stepNext  = seq.step;
      if (seq.phase == fetch) begin
         case (seq.step)
            cycle0: stepNext = cycle1;
            cycle1: stepNext = cycle2;
            cycle2: begin
               if (nWait)                       // Memory not ready, hold
                  stepNext = cycle3;
            end
            cycle3: begin
               phaseNext = execute;
               stepNext  = cycle0;
            end
            default: stepNext = cycle0;
         endcase
      end else begin
         case (seq.step)
            cycle0: begin
               if (seq.opcode inside {LDW, STW})
                  stepNext = cycle1;
               else
                  phaseNext = fetch;           // Single cycle ops
            end
            cycle1: stepNext = cycle2;
            cycle2: stepNext = cycle3;
            cycle3: begin
               if (nWait)                       // Data setup, stay in place
                  stepNext = cycle4;
            end
            default: begin
               phaseNext = fetch;
               stepNext  = cycle0;
            end
         endcase
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         seq.phase <= fetch;
         seq.step  <= cycle0;
      end else begin
         seq.phase <= phaseNext;
         seq.step  <= stepNext;
      end
   end

endmodule

//--- statusFlags.sv
// Status flags and branch test
`timescale 1ns/10ps
`include "cpu_defines.svh"

module statusFlags (
   input  logic                 Clock,
   input  logic                 nReset,
   input  logic [`FLAGS_W-1:0]  flags,
   input  logic                 flagsWe,
   input  isaPkg::branch_t      branchCode,
   output logic                 branchTaken
);

   import isaPkg::*;

   logic [`FLAGS_W-1:0] statusReg;
   logic zFlag;
   logic nFlag;
   logic vFlag;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         statusReg <= '0;
      else if (flagsWe)
         statusReg <= flags;              // Latched from the ALU result
   end

   assign zFlag = statusReg[`FLAG_Z];
   assign nFlag = statusReg[`FLAG_N];
   assign vFlag = statusReg[`FLAG_V];

   always_comb begin
      case (branchCode)
         BR, BWL: branchTaken = 1'b1;
         BNE:     branchTaken = !zFlag;
         BE:      branchTaken = zFlag;
         BLT:     branchTaken = nFlag != vFlag;  // Signed less than
         BGE:     branchTaken = nFlag == vFlag;
         // RET reloads the PC from the link register instead
         default: branchTaken = 1'b0;
      endcase
   end

endmodule
